//--- project.f
ddr_rd_pkg.sv
rstn_sync.sv
fifo_ddr3_read.sv
ddr3_read.sv
ddr_rd_top.sv
ddr_rd_sva.sv
tb_ddr_rd_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ddr_rd_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard *.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_ddr_rd_top.sv
`timescale 1ns/1ps

module tb_ddr_rd_top;

    typedef struct packed {
        ddr_rd_pkg::rd_id_t    id;
        ddr_rd_pkg::ddr_addr_t addr;
        ddr_rd_pkg::rd_len_t   len;
        logic [7:0]            ready_pct;   // percent of cycles with rd_rsp_ready high
    } req_row_t;

    logic                 clk;
    logic                 rstn;
    ddr_rd_pkg::rd_req_t  rd_req;
    logic                 rd_req_valid;
    logic                 rd_req_ready;
    ddr_rd_pkg::rd_rsp_t  rd_rsp;
    logic                 rd_rsp_valid;
    logic                 rd_rsp_ready;
    ddr_rd_pkg::ddr_cmd_t ddr_cmd;
    logic                 ddr_cmd_valid;
    logic                 ddr_cmd_ready;
    ddr_rd_pkg::ddr_ret_t ddr_ret;
    logic                 ddr_ret_valid;

    // id, address, length field, ready percent
    req_row_t rows [12] = '{
        '{4'h1, 28'h0000100, 8'd0,   8'd100},   // aligned single word
        '{4'h2, 28'h0000201, 8'd5,   8'd100},
        '{4'h3, 28'h000030a, 8'd12,  8'd80},
        '{4'h4, 28'h0000403, 8'd30,  8'd100},
        '{4'h5, 28'h0000504, 8'd7,   8'd60},
        '{4'h6, 28'h0000605, 8'd3,   8'd100},
        '{4'h7, 28'h0000716, 8'd20,  8'd100},
        '{4'h8, 28'h0000807, 8'd9,   8'd50},
        '{4'h9, 28'h0001003, 8'd255, 8'd100},   // three DDR commands
        '{4'ha, 28'h0002005, 8'd255, 8'd30},
        '{4'hb, 28'h0003000, 8'd200, 8'd30},
        '{4'hc, 28'h0003001, 8'd15,  8'd100}    // overlaps the row before
    };

    logic [31:0]           lfsr = 32'h9685f8e8;
    req_row_t              cur;
    logic                  row_active;
    int                    word_idx;
    ddr_rd_pkg::ddr_addr_t exp_cmd_addr;
    ddr_rd_pkg::ddr_addr_t ret_addr;     // next beat the DDR model returns
    ddr_rd_pkg::rd_id_t    ret_id;
    int                    beats_left;
    int                    ret_delay;

    ddr_rd_top ddr_rd_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic ddr_rd_pkg::word_t mem_word(input ddr_rd_pkg::ddr_addr_t a);
        return 32'ha5000000 ^ {4'h0, a};
    endfunction

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic ddr_model_step();
        ddr_rd_pkg::beat_t beat;
        int k;
        ddr_ret_valid = 1'b0;
        ddr_ret.last  = 1'b0;
        if (beats_left > 0) begin
            if (ret_delay > 0) begin
                ret_delay--;
            end else begin
                for (k = 0; k < ddr_rd_pkg::WORDS_PER_BEAT; k++) begin
                    beat[32*k +: 32] = mem_word(ret_addr + ddr_rd_pkg::ddr_addr_t'(k));
                end
                beats_left--;
                ddr_ret.data  = beat;
                ddr_ret.id    = ret_id;
                ddr_ret.last  = (beats_left == 0);
                ddr_ret_valid = 1'b1;
                ret_addr      = ret_addr + ddr_rd_pkg::ddr_addr_t'(ddr_rd_pkg::WORDS_PER_BEAT);
            end
        end
        ddr_cmd_ready = rand_bits(1) != 0;
        if (ddr_cmd_valid && ddr_cmd_ready) begin  // taken at the coming rising edge
            if (!row_active || beats_left != 0) begin
                stop_on_error("DDR command issued outside a request or during a burst");
            end
            check_value("ddr_cmd.addr", ddr_cmd.addr, exp_cmd_addr);
            check_value("ddr_cmd.id", ddr_cmd.id, cur.id);
            beats_left   = int'(ddr_cmd.len) + 1;
            exp_cmd_addr = exp_cmd_addr +
                           ddr_rd_pkg::ddr_addr_t'(beats_left * ddr_rd_pkg::WORDS_PER_BEAT);
            ret_addr     = ddr_cmd.addr;
            ret_id       = ddr_cmd.id;
            ret_delay    = int'(rand_bits(3));
        end
    endtask

    task automatic client_step();
        rd_rsp_ready = (rand_bits(7) % 100) < cur.ready_pct;
        if (rd_rsp_valid && rd_rsp_ready) begin
            if (!row_active) begin
                stop_on_error("response word seen with no request in progress");
            end
            check_value("rd_rsp.id", rd_rsp.id, cur.id);
            check_value("rd_rsp.data", rd_rsp.data,
                        mem_word(cur.addr + ddr_rd_pkg::ddr_addr_t'(word_idx)));
            check_value("rd_rsp.resp", rd_rsp.resp, 2'b00);
            check_value("rd_rsp.last", rd_rsp.last, word_idx == int'(cur.len));
            row_active = !rd_rsp.last;
            word_idx++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        ddr_model_step();
        client_step();
    endtask

    initial begin
        int r;
        rstn          = 1'b0;
        rd_req        = '0;
        rd_req_valid  = 1'b0;
        rd_rsp_ready  = 1'b0;
        ddr_cmd_ready = 1'b0;
        ddr_ret       = '0;
        ddr_ret_valid = 1'b0;
        cur           = '0;
        row_active    = 1'b0;
        word_idx      = 0;
        exp_cmd_addr  = '0;
        ret_addr      = '0;
        ret_id        = '0;
        beats_left    = 0;
        ret_delay     = 0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        repeat (4) next_cycle();
        check_value("rd_rsp_valid", rd_rsp_valid, 1'b0);
        check_value("ddr_cmd_valid", ddr_cmd_valid, 1'b0);
        check_value("rd_req_ready", rd_req_ready, 1'b1);

        for (r = 0; r < $size(rows); r++) begin
            cur          = rows[r];
            word_idx     = 0;
            row_active   = 1'b1;
            exp_cmd_addr = cur.addr & ~ddr_rd_pkg::ddr_addr_t'(7);  // beat aligned
            rd_req.id    = cur.id;
            rd_req.addr  = cur.addr;
            rd_req.len   = cur.len;
            rd_req.burst = 2'b01;
            rd_req_valid = 1'b1;
            while (!rd_req_ready) next_cycle();
            next_cycle();
            rd_req_valid = 1'b0;
            while (row_active) next_cycle();
            while (!rd_req_ready) next_cycle();   // flush done
            // commands end right after the beat holding addr+len
            check_value("command end address", exp_cmd_addr,
                        ((cur.addr + ddr_rd_pkg::ddr_addr_t'(cur.len)) &
                         ~ddr_rd_pkg::ddr_addr_t'(7)) + ddr_rd_pkg::ddr_addr_t'(8));
        end
        $display("Verification passed");
        $finish;
    end

    // watchdog limit scales with the total word count of the table
    initial begin
        int i;
        int wd_cycles;
        wd_cycles = 2000;
        for (i = 0; i < $size(rows); i++) begin
            wd_cycles += (int'(rows[i].len) + 1) * 40;
        end
        repeat (wd_cycles) @(posedge clk);
        stop_on_error($sformatf("timeout: requests not finished within %0d cycles", wd_cycles));
    end

endmodule

//--- ddr_rd_sva.sv
`timescale 1ns/1ps

module ddr_rd_sva (
    input logic                 clk,
    input logic                 ddr_rstn_sync,
    input logic                 rd_req_valid,
    input logic                 rd_req_ready,
    input ddr_rd_pkg::rd_rsp_t  rd_rsp,
    input logic                 rd_rsp_valid,
    input logic                 rd_rsp_ready,
    input ddr_rd_pkg::ddr_cmd_t ddr_cmd,
    input logic                 ddr_cmd_valid
);

    logic in_xfer;  // from request acceptance to the last word

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            in_xfer <= 1'b0;
        end else if (rd_req_valid && rd_req_ready) begin
            in_xfer <= 1'b1;
        end else if (rd_rsp_valid && rd_rsp_ready && rd_rsp.last) begin
            in_xfer <= 1'b0;
        end
    end

    rsp_hold: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp))
        else $error("response changed while stalled");

    cmd_aligned: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        ddr_cmd_valid |-> (ddr_cmd.addr[2:0] == 3'b000))
        else $error("DDR command address not beat aligned");

    req_blocked: assert property (@(posedge clk) disable iff (!ddr_rstn_sync)
        in_xfer |-> !rd_req_ready)
        else $error("rd_req_ready high during a transfer");

endmodule

bind ddr_rd_top ddr_rd_sva ddr_rd_sva_i (
    .clk           (clk),
    .ddr_rstn_sync (ddr_rstn_sync),
    .rd_req_valid  (rd_req_valid),
    .rd_req_ready  (rd_req_ready),
    .rd_rsp        (rd_rsp),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp_ready  (rd_rsp_ready),
    .ddr_cmd       (ddr_cmd),
    .ddr_cmd_valid (ddr_cmd_valid)
);

//--- ddr_rd_top.sv
`timescale 1ns/1ps

module ddr_rd_top (
    input  logic                  clk,
    input  logic                  rstn,

    input  ddr_rd_pkg::rd_req_t   rd_req,
    input  logic                  rd_req_valid,
    output logic                  rd_req_ready,

    output ddr_rd_pkg::rd_rsp_t   rd_rsp,
    output logic                  rd_rsp_valid,
    input  logic                  rd_rsp_ready,

    output ddr_rd_pkg::ddr_cmd_t  ddr_cmd,
    output logic                  ddr_cmd_valid,
    input  logic                  ddr_cmd_ready,

    input  ddr_rd_pkg::ddr_ret_t  ddr_ret,
    input  logic                  ddr_ret_valid
);

    logic              ddr_rstn_sync;
    logic              fifo_flush;
    logic              fifo_rd_en;
    ddr_rd_pkg::word_t fifo_rd_data;
    logic              fifo_empty;
    logic              fifo_almost_empty;

    rstn_sync rstn_sync_i (
        .clk           (clk),
        .rstn          (rstn),
        .ddr_rstn_sync (ddr_rstn_sync)
    );

    ddr3_read ddr3_read_i (
        .clk               (clk),
        .ddr_rstn_sync     (ddr_rstn_sync),
        .rd_req            (rd_req),
        .rd_req_valid      (rd_req_valid),
        .rd_req_ready      (rd_req_ready),
        .rd_rsp            (rd_rsp),
        .rd_rsp_valid      (rd_rsp_valid),
        .rd_rsp_ready      (rd_rsp_ready),
        .ddr_cmd           (ddr_cmd),
        .ddr_cmd_valid     (ddr_cmd_valid),
        .ddr_cmd_ready     (ddr_cmd_ready),
        .ddr_ret_valid     (ddr_ret_valid),
        .ddr_ret_last      (ddr_ret.last),     // ends the data phase
        .fifo_flush        (fifo_flush),
        .fifo_rd_en        (fifo_rd_en),
        .fifo_rd_data      (fifo_rd_data),
        .fifo_empty        (fifo_empty),
        .fifo_almost_empty (fifo_almost_empty)
    );

    // return beats go straight into the fifo with no back-pressure
    fifo_ddr3_read fifo_ddr3_read_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .flush         (fifo_flush),
        .wr_en         (ddr_ret_valid),
        .wr_data       (ddr_ret.data),
        .rd_en         (fifo_rd_en),
        .rd_data       (fifo_rd_data),
        .empty         (fifo_empty),
        .almost_empty  (fifo_almost_empty)
    );

endmodule

//--- ddr3_read.sv
`timescale 1ns/1ps

module ddr3_read (
    input  logic                  clk,
    input  logic                  ddr_rstn_sync,

    input  ddr_rd_pkg::rd_req_t   rd_req,
    input  logic                  rd_req_valid,
    output logic                  rd_req_ready,

    output ddr_rd_pkg::rd_rsp_t   rd_rsp,
    output logic                  rd_rsp_valid,
    input  logic                  rd_rsp_ready,

    output ddr_rd_pkg::ddr_cmd_t  ddr_cmd,
    output logic                  ddr_cmd_valid,
    input  logic                  ddr_cmd_ready,
    input  logic                  ddr_ret_valid,
    input  logic                  ddr_ret_last,

    output logic                  fifo_flush,
    output logic                  fifo_rd_en,
    input  ddr_rd_pkg::word_t     fifo_rd_data,
    input  logic                  fifo_empty,
    input  logic                  fifo_almost_empty
);

    ddr_rd_pkg::rd_state_t state, state_nxt;

    ddr_rd_pkg::ddr_addr_t cmd_addr;     // next aligned command address
    ddr_rd_pkg::rd_id_t    id_q;
    ddr_rd_pkg::beat_cnt_t beats_rem;    // beats not yet requested
    ddr_rd_pkg::rd_len_t   word_cnt;     // words left after the current one
    ddr_rd_pkg::ddr_len_t  cmd_len;
    ddr_rd_pkg::beat_cnt_t cmd_beats;

    logic [ddr_rd_pkg::BEAT_WORD_W-1:0] drop_cnt;   // leading words still to discard
    logic [ddr_rd_pkg::FLUSH_CNT_W-1:0] flush_cnt;

    ddr_rd_pkg::ddr_addr_t req_end;
    ddr_rd_pkg::ddr_addr_t beat_span;

    logic req_xfer;
    logic cmd_xfer;
    logic rsp_xfer;
    logic last_xfer;
    logic active;
    logic out_fresh;    // registered fifo output not consumed yet
    logic drop_now;
    logic consume;

    assign req_xfer  = rd_req_valid && rd_req_ready;
    assign cmd_xfer  = ddr_cmd_valid && ddr_cmd_ready;
    assign rsp_xfer  = rd_rsp_valid && rd_rsp_ready;
    assign last_xfer = rsp_xfer && rd_rsp.last;

    assign active = (state == ddr_rd_pkg::ST_WAIT) ||
                    (state == ddr_rd_pkg::ST_TRANS_ADDR) ||
                    (state == ddr_rd_pkg::ST_TRANS_DATA);

    // beats from the one holding addr through the one holding addr+len
    assign req_end   = rd_req.addr + ddr_rd_pkg::ddr_addr_t'(rd_req.len);
    assign beat_span = (req_end >> ddr_rd_pkg::BEAT_WORD_W) -
                       (rd_req.addr >> ddr_rd_pkg::BEAT_WORD_W);

    // clip to the native burst limit
    assign cmd_len = (beats_rem > ddr_rd_pkg::beat_cnt_t'(ddr_rd_pkg::DDR_MAX_BEATS)) ?
                     ddr_rd_pkg::ddr_len_t'(ddr_rd_pkg::DDR_MAX_BEATS - 1) :
                     ddr_rd_pkg::ddr_len_t'(beats_rem - 1'b1);
    assign cmd_beats = ddr_rd_pkg::beat_cnt_t'(cmd_len) + 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            ddr_rd_pkg::ST_IDLE: begin
                if (req_xfer) state_nxt = ddr_rd_pkg::ST_WAIT;
            end
            ddr_rd_pkg::ST_WAIT: begin
                if (last_xfer) begin
                    state_nxt = ddr_rd_pkg::ST_FLUSH;
                end else if (fifo_almost_empty && (beats_rem != '0)) begin
                    state_nxt = ddr_rd_pkg::ST_TRANS_ADDR;
                end
            end
            ddr_rd_pkg::ST_TRANS_ADDR: begin
                if (cmd_xfer) state_nxt = ddr_rd_pkg::ST_TRANS_DATA;
            end
            ddr_rd_pkg::ST_TRANS_DATA: begin
                if (ddr_ret_valid && ddr_ret_last) state_nxt = ddr_rd_pkg::ST_WAIT;
            end
            ddr_rd_pkg::ST_FLUSH: begin
                if (flush_cnt == ddr_rd_pkg::FLUSH_CNT_W'(ddr_rd_pkg::FLUSH_CYCLES - 1)) begin
                    state_nxt = ddr_rd_pkg::ST_IDLE;
                end
            end
            default: state_nxt = ddr_rd_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            state <= ddr_rd_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            flush_cnt <= '0;
        end else if (state == ddr_rd_pkg::ST_FLUSH) begin
            flush_cnt <= flush_cnt + 1'b1;
        end else begin
            flush_cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            beats_rem <= '0;
        end else if (req_xfer) begin
            beats_rem <= ddr_rd_pkg::beat_cnt_t'(beat_span) + 1'b1;
        end else if (cmd_xfer) begin
            beats_rem <= beats_rem - cmd_beats;
        end
    end

    // aligned start address, then step past each issued burst
    always_ff @(posedge clk) begin
        if (req_xfer) begin
            cmd_addr <= rd_req.addr & ~ddr_rd_pkg::ddr_addr_t'(ddr_rd_pkg::WORDS_PER_BEAT - 1);
            id_q     <= rd_req.id;
        end else if (cmd_xfer) begin
            cmd_addr <= cmd_addr + ddr_rd_pkg::ddr_addr_t'(cmd_beats) *
                        ddr_rd_pkg::ddr_addr_t'(ddr_rd_pkg::WORDS_PER_BEAT);
        end
    end

    // read side
    assign drop_now   = out_fresh && (drop_cnt != '0);
    assign consume    = drop_now || rsp_xfer;
    assign fifo_rd_en = active && !fifo_empty && (!out_fresh || consume) && !last_xfer;

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            out_fresh <= 1'b0;
        end else if (fifo_flush || last_xfer) begin
            out_fresh <= 1'b0;
        end else if (fifo_rd_en) begin
            out_fresh <= 1'b1;
        end else if (consume) begin
            out_fresh <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            drop_cnt <= '0;
        end else if (req_xfer) begin
            drop_cnt <= rd_req.addr[ddr_rd_pkg::BEAT_WORD_W-1:0];
        end else if (drop_now) begin
            drop_cnt <= drop_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            word_cnt <= '0;
        end else if (req_xfer) begin
            word_cnt <= rd_req.len;
        end else if (rsp_xfer && (word_cnt != '0)) begin
            word_cnt <= word_cnt - 1'b1;
        end
    end

    assign rd_req_ready = (state == ddr_rd_pkg::ST_IDLE);
    assign rd_rsp_valid = out_fresh && (drop_cnt == '0);
    assign fifo_flush   = (state == ddr_rd_pkg::ST_FLUSH);

    always_comb begin
        rd_rsp.id   = id_q;         // in-order only
        rd_rsp.data = fifo_rd_data;
        rd_rsp.resp = 2'b00;
        rd_rsp.last = (word_cnt == '0);
    end

    assign ddr_cmd_valid = (state == ddr_rd_pkg::ST_TRANS_ADDR);

    always_comb begin
        ddr_cmd.addr = cmd_addr;
        ddr_cmd.len  = cmd_len;
        ddr_cmd.id   = id_q;
    end

endmodule

//--- fifo_ddr3_read.sv
`timescale 1ns/1ps

module fifo_ddr3_read (
    input  logic               clk,
    input  logic               ddr_rstn_sync,
    input  logic               flush,
    input  logic               wr_en,
    input  ddr_rd_pkg::beat_t  wr_data,
    input  logic               rd_en,
    output ddr_rd_pkg::word_t  rd_data,
    output logic               empty,
    output logic               almost_empty
);

    ddr_rd_pkg::beat_t mem [ddr_rd_pkg::FIFO_BEATS];

    // one extra wrap bit on each pointer
    logic [ddr_rd_pkg::FIFO_BEAT_AW:0] wr_ptr;   // in beats
    logic [ddr_rd_pkg::FIFO_WORD_AW:0] rd_ptr;   // in words
    logic [ddr_rd_pkg::FIFO_WORD_AW:0] word_cnt;

    logic [ddr_rd_pkg::FIFO_BEAT_AW-1:0] wr_idx;
    logic [ddr_rd_pkg::FIFO_BEAT_AW-1:0] rd_beat_idx;
    logic [ddr_rd_pkg::BEAT_WORD_W-1:0]  rd_word_sel;
    ddr_rd_pkg::beat_t                   rd_beat;
    logic                                rd_fire;

    assign wr_idx      = wr_ptr[ddr_rd_pkg::FIFO_BEAT_AW-1:0];
    assign rd_beat_idx = rd_ptr[ddr_rd_pkg::FIFO_WORD_AW-1:ddr_rd_pkg::BEAT_WORD_W];
    assign rd_word_sel = rd_ptr[ddr_rd_pkg::BEAT_WORD_W-1:0];
    assign rd_beat     = mem[rd_beat_idx];

    // write pointer scaled to words before the compare
    assign word_cnt = {wr_ptr, {ddr_rd_pkg::BEAT_WORD_W{1'b0}}} - rd_ptr;

    assign empty        = (word_cnt == '0);
    assign almost_empty = (word_cnt < ddr_rd_pkg::FIFO_AE_BEATS * ddr_rd_pkg::WORDS_PER_BEAT);

    assign rd_fire = rd_en && !empty && !flush;

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // beat storage
    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read port gives data the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data <= rd_beat[rd_word_sel * $bits(ddr_rd_pkg::word_t)
                               +: $bits(ddr_rd_pkg::word_t)];
        end
    end

endmodule

//--- rstn_sync.sv
`timescale 1ns/1ps

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic ddr_rstn_sync
);

    logic rstn_meta; // first stage may go metastable on release

    // assert at once, release after two rising edges
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_meta     <= 1'b0;
            ddr_rstn_sync <= 1'b0;
        end else begin
            rstn_meta     <= 1'b1;
            ddr_rstn_sync <= rstn_meta;
        end
    end

endmodule

//--- ddr_rd_pkg.sv
package ddr_rd_pkg;

    localparam int WORDS_PER_BEAT = 8;
    localparam int DDR_MAX_BEATS  = 16;   // 4-bit native length field
    localparam int FIFO_BEATS     = 32;
    localparam int FIFO_AE_BEATS  = 16;
    localparam int FLUSH_CYCLES   = 16;

    // derived widths
    localparam int BEAT_WORD_W  = $clog2(WORDS_PER_BEAT);     // word select inside a beat
    localparam int FIFO_BEAT_AW = $clog2(FIFO_BEATS);
    localparam int FIFO_WORD_AW = FIFO_BEAT_AW + BEAT_WORD_W;
    localparam int FLUSH_CNT_W  = $clog2(FLUSH_CYCLES);

    typedef logic [27:0]  ddr_addr_t;   // word address
    typedef logic [3:0]   rd_id_t;
    typedef logic [7:0]   rd_len_t;     // words minus one
    typedef logic [3:0]   ddr_len_t;    // beats minus one
    typedef logic [31:0]  word_t;
    typedef logic [255:0] beat_t;       // word 0 in the low bits
    typedef logic [5:0]   beat_cnt_t;   // up to 33 beats per request

    typedef struct packed {
        rd_id_t     id;
        ddr_addr_t  addr;
        rd_len_t    len;
        logic [1:0] burst;      // incrementing only
    } rd_req_t;

    typedef struct packed {
        rd_id_t     id;
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } rd_rsp_t;

    typedef struct packed {
        ddr_addr_t addr;
        ddr_len_t  len;
        rd_id_t    id;
    } ddr_cmd_t;

    typedef struct packed {
        beat_t  data;
        rd_id_t id;
        logic   last;
    } ddr_ret_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT,
        ST_TRANS_ADDR,
        ST_TRANS_DATA,
        ST_FLUSH
    } rd_state_t;

endpackage
